/* src/mapper_pkg.sv */
/* shared types and register map for the 68000 bus mapper
   import with mapper_pkg::* inside a module body */
`default_nettype none

package mapper_pkg;

    localparam int NUM_REGIONS = 8;    // programmable windows
    localparam int REG_COUNT   = 32;   // byte-wide mapper registers

    // register map
    localparam logic [4:0] REG_SND_LATCH   = 5'd3;  // sound CPU latch
    localparam logic [4:0] REG_REGION_BASE = 5'd16; // ctrl at 16+2r, base at 17+2r

    localparam logic [2:0] FC_INT_ACK = 3'd7;       // cpu space, interrupt acknowledge

    // CPU bus as seen by the mapper
    typedef struct packed {
        logic        as_n;  // address strobe
        logic [1:0]  ds_n;  // upper/lower data strobes
        logic [1:0]  wr_n;  // byte write strobes
        logic [2:0]  fc;    // function code
        logic [23:1] addr;  // word address
        logic [15:0] dout;  // cpu write data
    } cpu_bus_t;

    // one register write from the protection MCU
    typedef struct packed {
        logic       wr;
        logic [4:0] addr;
        logic [7:0] data;
    } mcu_wr_t;

    // window size sets how many upper address bits take part in the compare
    typedef enum logic [1:0] {
        SZ_64K  = 2'd0,     // 8 bits
        SZ_128K = 2'd1,     // 7 bits
        SZ_512K = 2'd2,     // 5 bits
        SZ_2M   = 2'd3      // 3 bits
    } region_size_e;

    typedef struct packed {
        logic [7:0]   base;
        region_size_e size;
        logic [1:0]   waits;  // extra acknowledge periods
    } region_cfg_t;

    typedef region_cfg_t [NUM_REGIONS-1:0] region_cfg_arr_t;

    // acknowledge sequencer
    typedef enum logic [1:0] {
        IDLE,
        COUNT,
        ACK
    } dtack_state_e;

endpackage

`default_nettype wire

/* src/mapper_regs.sv */
/* mapper register file, written by the CPU until the MCU takes over
   also unpacks the window config and keeps the sound latch flag */
`timescale 1ns/1ps
`default_nettype none

module mapper_regs (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire mapper_pkg::cpu_bus_t        cpu,
    input  wire mapper_pkg::mcu_wr_t         mcu,
    input  wire logic                        unmapped,   // no window claims the address
    input  wire logic                        sndmap_rd,  // sound CPU reads the latch
    output      mapper_pkg::region_cfg_arr_t cfg,
    output      logic [7:0]                  sndmap_dout,
    output      logic                        sndmap_obf
);
    import mapper_pkg::*;

    logic [7:0] mmr [REG_COUNT];
    logic       cpu_sel;    // 1 while the CPU owns register writes
    logic       cpu_wr;
    logic       wren;
    logic [4:0] asel;
    logic [7:0] din;

    // registers live in the hole left by the windows, low byte lane only
    assign cpu_wr = ~cpu.as_n & ~cpu.wr_n[0] & unmapped;

    // write source mux
    always_comb begin
        if (mcu.wr) begin           // MCU write always lands
            asel = mcu.addr;
            din  = mcu.data;
            wren = 1'b1;
        end else begin
            asel = cpu.addr[5:1];
            din  = cpu.dout[7:0];
            wren = cpu_sel & cpu_wr;    // repeats each clock, same value
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                mmr[i] <= 8'd0;
            end
            cpu_sel    <= 1'b1;
            sndmap_obf <= 1'b0;
        end else begin
            if (mcu.wr) cpu_sel <= 1'b0;    // sticky until reset
            if (wren) begin
                mmr[asel] <= din;
                if (asel == REG_SND_LATCH) sndmap_obf <= 1'b1;
            end
            if (sndmap_rd) sndmap_obf <= 1'b0; // read beats a same-clock write
        end
    end

    assign sndmap_dout = mmr[REG_SND_LATCH];

    // window r: control byte then base byte
    always_comb begin
        for (int r = 0; r < NUM_REGIONS; r++) begin
            cfg[r].base  = mmr[REG_REGION_BASE + 2*r + 1];
            cfg[r].size  = region_size_e'(mmr[REG_REGION_BASE + 2*r][1:0]);
            cfg[r].waits = mmr[REG_REGION_BASE + 2*r][3:2];
        end
    end

endmodule

`default_nettype wire

/* src/region_decoder.sv */
/* priority decode of the CPU address against the eight windows
   purely combinational, gives the one-hot select and its wait count */
`timescale 1ns/1ps
`default_nettype none

module region_decoder (
    input  wire logic [23:1]                        addr,
    input  wire logic [2:0]                         fc,
    input  wire mapper_pkg::region_cfg_arr_t        cfg,
    output      logic [mapper_pkg::NUM_REGIONS-1:0] active,
    output      logic                               unmapped,
    output      logic [1:0]                         waits
);
    import mapper_pkg::*;

    logic [NUM_REGIONS-1:0] hit;    // raw matches, may overlap
    logic                   iack;
    logic                   found;

    // bits of the base that take part in the compare
    function automatic logic [7:0] size_mask(input region_size_e size);
        case (size)
            SZ_64K:  size_mask = 8'hff;
            SZ_128K: size_mask = 8'hfe;
            SZ_512K: size_mask = 8'hf8;
            default: size_mask = 8'he0;  // 2 MB
        endcase
    endfunction

    assign iack = fc == FC_INT_ACK; // vector fetch, not a memory access

    always_comb begin
        for (int r = 0; r < NUM_REGIONS; r++) begin
            hit[r] = ((addr[23:16] ^ cfg[r].base) & size_mask(cfg[r].size)) == 8'd0;
        end
    end

    // lowest index wins
    always_comb begin
        active = '0;
        waits  = 2'd0;
        found  = 1'b0;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            if (hit[r] && !found && !iack) begin
                active[r] = 1'b1;
                waits     = cfg[r].waits;
                found     = 1'b1;
            end
        end
    end

    assign unmapped = ~found;   // opens the register window

endmodule

`default_nettype wire

/* src/dtack_gen.sv */
/* CPU clock enables from a fractional divider and DTACK timing
   dtack_n falls after 1+waits enable pulses, held until as_n rises */
`timescale 1ns/1ps
`default_nettype none

module dtack_gen #(
    parameter int CEN_NUM = 29,     // enables per CEN_DEN clocks
    parameter int CEN_DEN = 146
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire mapper_pkg::cpu_bus_t cpu,
    input  wire logic                 bus_cs,   // access goes to a shared bus
    input  wire logic                 bus_busy, // shared bus not ready
    input  wire logic [1:0]           waits,
    output      logic                 cpu_cen,
    output      logic                 cpu_cenb,
    output      logic                 dtack_n
);
    import mapper_pkg::*;

    // accumulator runs at twice the rate, odd and even overflows split cen/cenb
    localparam int          AW    = $clog2(CEN_DEN + 2*CEN_NUM) + 1;
    localparam logic [AW-1:0] STEP  = AW'(2*CEN_NUM);
    localparam logic [AW-1:0] DEN_W = AW'(CEN_DEN);

    logic [AW-1:0] acc;
    logic [AW-1:0] sum;
    logic          tick;
    logic          phase;   // selects which enable the next overflow gives

    assign sum  = acc + STEP;
    assign tick = sum >= DEN_W;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc      <= '0;
            phase    <= 1'b0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            acc      <= tick ? sum - DEN_W : sum;
            phase    <= phase ^ tick;
            cpu_cen  <= tick & ~phase;
            cpu_cenb <= tick & phase;   // half a period after cpu_cen
        end
    end

    dtack_state_e state;
    logic [1:0]   cnt;          // enable pulses seen so far
    logic         strobe;
    logic         count_en;

    assign strobe   = ~cpu.as_n & ~&cpu.ds_n;
    assign count_en = cpu_cen & ~(bus_cs & bus_busy);   // stall on back-pressure

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= 2'd0;
        end else begin
            case (state)
                IDLE: if (strobe) begin
                    if (count_en && waits == 2'd0) begin
                        state <= ACK;
                    end else begin
                        state <= COUNT;
                        cnt   <= count_en ? 2'd1 : 2'd0;
                    end
                end
                COUNT: if (cpu.as_n) begin
                    state <= IDLE;      // cycle dropped early
                end else if (count_en) begin
                    if (cnt == waits) state <= ACK;
                    else cnt <= cnt + 2'd1;
                end
                ACK: if (cpu.as_n) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign dtack_n = state != ACK;

endmodule

`default_nettype wire

/* src/irq_ctrl.sv */
/* level 4 autovectored interrupt raised on the vertical blank rising edge
   vpa_n answers the acknowledge cycle, which also drops the request */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire mapper_pkg::cpu_bus_t cpu,
    input  wire logic                 vint,     // vertical blank
    output      logic [2:0]           ipl_n,
    output      logic                 vpa_n
);
    import mapper_pkg::*;

    logic last_vint;
    logic irq_pend;
    logic iack;

    assign iack  = cpu.fc == FC_INT_ACK && !cpu.as_n;
    assign vpa_n = ~iack;                               // autovector
    assign ipl_n = irq_pend ? 3'b011 : 3'b111;          // level 4 active low

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_vint <= 1'b0;
            irq_pend  <= 1'b0;
        end else begin
            last_vint <= vint;
            if (iack) begin
                irq_pend <= 1'b0;
            end else if (vint && !last_vint) begin
                irq_pend <= 1'b1;   // rising edge only
            end
        end
    end

endmodule

`default_nettype wire

/* src/cpu_mapper_top.sv */
/* top of the 68000 bus mapper, ties registers, decoder, DTACK and interrupts
   CEN_NUM/CEN_DEN set the CPU clock enable ratio */
`timescale 1ns/1ps
`default_nettype none

module cpu_mapper_top #(
    parameter int CEN_NUM = 29,
    parameter int CEN_DEN = 146
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire mapper_pkg::cpu_bus_t               cpu,
    input  wire mapper_pkg::mcu_wr_t                mcu,
    input  wire logic                               bus_cs,
    input  wire logic                               bus_busy,
    input  wire logic                               vint,
    input  wire logic                               sndmap_rd,
    output      logic                               cpu_cen,
    output      logic                               cpu_cenb,
    output      logic                               dtack_n,
    output      logic [2:0]                         ipl_n,
    output      logic                               vpa_n,
    output      logic [mapper_pkg::NUM_REGIONS-1:0] active,
    output      logic [7:0]                         sndmap_dout,
    output      logic                               sndmap_obf
);
    import mapper_pkg::*;

    region_cfg_arr_t cfg;       // window setup from the register file
    logic            unmapped;  // no window hit, registers are visible
    logic [1:0]      waits;     // wait states of the selected window

    mapper_regs u_mapper_regs (
        .clk         (clk),
        .rst         (rst),
        .cpu         (cpu),
        .mcu         (mcu),
        .unmapped    (unmapped),
        .sndmap_rd   (sndmap_rd),
        .cfg         (cfg),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf)
    );

    region_decoder u_region_decoder (
        .addr     (cpu.addr),
        .fc       (cpu.fc),
        .cfg      (cfg),
        .active   (active),
        .unmapped (unmapped),
        .waits    (waits)
    );

    dtack_gen #(
        .CEN_NUM (CEN_NUM),
        .CEN_DEN (CEN_DEN)
    ) u_dtack_gen (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .bus_cs   (bus_cs),
        .bus_busy (bus_busy),
        .waits    (waits),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb),
        .dtack_n  (dtack_n)
    );

    irq_ctrl u_irq_ctrl (
        .clk   (clk),
        .rst   (rst),
        .cpu   (cpu),
        .vint  (vint),
        .ipl_n (ipl_n),
        .vpa_n (vpa_n)
    );

endmodule

`default_nettype wire

/* verif/mapper_properties.sv */
/* concurrent checks on the CPU handshake and interrupt acknowledge
   bound into every cpu_mapper_top instance */
`timescale 1ns/1ps
`default_nettype none

module mapper_properties (
    input wire logic                               clk,
    input wire logic                               rst,
    input wire mapper_pkg::cpu_bus_t               cpu,
    input wire logic                               dtack_n,
    input wire logic                               vpa_n,
    input wire logic [mapper_pkg::NUM_REGIONS-1:0] active
);
    import mapper_pkg::*;

    // dtack_n back high in the clock after the strobe ends
    a_dtack_release: assert property (@(posedge clk) disable iff (rst)
        $rose(cpu.as_n) |=> dtack_n)
        else $error("dtack_n still low one clock after as_n rose");

    a_active_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(active))
        else $error("more than one window selected");

    // autovector only inside an acknowledge cycle
    a_vpa_iack: assert property (@(posedge clk) disable iff (rst)
        !vpa_n |-> (cpu.fc == FC_INT_ACK && !cpu.as_n))
        else $error("vpa_n low outside an interrupt acknowledge cycle");

endmodule

bind cpu_mapper_top mapper_properties u_mapper_properties (
    .clk     (clk),
    .rst     (rst),
    .cpu     (cpu),
    .dtack_n (dtack_n),
    .vpa_n   (vpa_n),
    .active  (active)
);

`default_nettype wire

/* verif/mapper_tb.sv */
/* testbench for the 68000 bus mapper that runs CPU and MCU cycles against cpu_mapper_top
   window decode is checked every clock against a reference model of the registers */
`timescale 1ns/1ps
`default_nettype none

module mapper_tb;
    import mapper_pkg::*;

    localparam int CEN_NUM = 29;        // CPU clock enable ratio
    localparam int CEN_DEN = 146;

    logic       clk = 1'b0;
    logic       rst;
    cpu_bus_t   cpu;
    mcu_wr_t    mcu;
    logic       bus_cs;
    logic       bus_busy;
    logic       vint;
    logic       sndmap_rd;
    logic       cpu_cen;
    logic       cpu_cenb;
    logic       dtack_n;
    logic       vpa_n;
    logic [2:0] ipl_n;
    logic [7:0] active;
    logic [7:0] sndmap_dout;
    logic       sndmap_obf;

    // shadow of the window registers
    logic [7:0] m_base  [NUM_REGIONS];
    logic [1:0] m_size  [NUM_REGIONS];
    logic [1:0] m_waits [NUM_REGIONS];
    logic       cpu_owns;               // CPU still owns register writes
    logic [7:0] snd_byte;

    logic       cen_last;               // last enable pulse was cpu_cen
    int         cen_cnt;
    int         clk_cnt;

    cpu_mapper_top u_cpu_mapper_top (
        .clk(clk), .rst(rst), .cpu(cpu), .mcu(mcu), .bus_cs(bus_cs), .bus_busy(bus_busy),
        .vint(vint), .sndmap_rd(sndmap_rd), .cpu_cen(cpu_cen), .cpu_cenb(cpu_cenb),
        .dtack_n(dtack_n), .ipl_n(ipl_n), .vpa_n(vpa_n), .active(active),
        .sndmap_dout(sndmap_dout), .sndmap_obf(sndmap_obf)
    );

    always #5 clk = ~clk;   // 100 MHz

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    // compared bits per size code are 8, 7, 5, 3; lowest window wins, none on iack
    function automatic logic [7:0] decode_ref(input logic [23:1] addr, input logic [2:0] fc);
        int         bits;
        logic [7:0] mask;
        decode_ref = 8'h00;
        if (fc != FC_INT_ACK) begin
            for (int r = NUM_REGIONS - 1; r >= 0; r--) begin   // downward so lower index wins
                case (m_size[r])
                    2'd0:    bits = 8;
                    2'd1:    bits = 7;
                    2'd2:    bits = 5;
                    default: bits = 3;
                endcase
                mask = 8'hff << (8 - bits);
                if (((addr[23:16] ^ m_base[r]) & mask) == 8'h00) decode_ref = 8'h01 << r;
            end
        end
    endfunction

    task automatic model_write(input logic [4:0] idx, input logic [7:0] data);
        int r;
        if (idx >= REG_REGION_BASE) begin
            r = (int'(idx) - int'(REG_REGION_BASE)) / 2;
            if (idx[0]) begin
                m_base[r] = data;               // odd index holds the base
            end else begin
                m_size[r]  = data[1:0];
                m_waits[r] = data[3:2];
            end
        end
    endtask

    // bases in 0xc0..0xdf would swallow the register window at 0xc4xxxx
    function automatic logic [7:0] random_base();
        logic [7:0] b;
        do b = 8'($urandom); while (b[7:5] == 3'b110);
        return b;
    endfunction

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    // one 68000 cycle that counts cpu_cen pulses until dtack_n falls
    task automatic cpu_cycle(input logic [23:0] byte_addr, input logic [2:0] fc,
                             input logic wr, input logic [15:0] data);
        int         pulses;
        int         n;
        int         exp_waits;
        logic [7:0] hit;
        hit       = decode_ref(byte_addr[23:1], fc);
        exp_waits = 0;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            if (hit[r]) exp_waits = m_waits[r];
        end
        cpu.addr = byte_addr[23:1];
        cpu.fc   = fc;
        cpu.dout = data;
        cpu.wr_n = wr ? 2'b00 : 2'b11;
        cpu.ds_n = 2'b00;
        cpu.as_n = 1'b0;
        pulses   = cpu_cen;     // this one is seen at the next edge
        n        = 0;
        do begin
            step_clock();
            check_equal("vpa_n", vpa_n, fc != FC_INT_ACK);
            if (dtack_n) pulses += cpu_cen;
            n++;
            if (n > 200) fail_now("timeout: dtack_n never went low during a CPU cycle");
        end while (dtack_n);
        if (!bus_cs) check_equal("cpu_cen pulses to dtack_n", pulses, 1 + exp_waits);
        cpu.as_n = 1'b1;
        cpu.ds_n = 2'b11;
        cpu.wr_n = 2'b11;
        n        = 0;
        do begin
            step_clock();
            n++;
            if (n > 10) fail_now("timeout: dtack_n stayed low after as_n rose");
        end while (!dtack_n);
    endtask

    task automatic cpu_reg_write(input logic [4:0] idx, input logic [7:0] data);
        cpu_cycle({8'hc4, 10'h000, idx, 1'b0}, 3'd5, 1'b1, {8'h00, data});
        if (cpu_owns) model_write(idx, data);
    endtask

    task automatic mcu_write(input logic [4:0] idx, input logic [7:0] data);
        mcu.wr   = 1'b1;
        mcu.addr = idx;
        mcu.data = data;
        step_clock();
        mcu.wr = 1'b0;
        model_write(idx, data);     // visible from this edge on
        cpu_owns = 1'b0;
    endtask

    task automatic program_window(input int r, input logic [7:0] ctrl, input logic [7:0] base);
        cpu_reg_write(5'(int'(REG_REGION_BASE) + 2*r), ctrl);
        cpu_reg_write(5'(int'(REG_REGION_BASE) + 2*r + 1), base);
    endtask

    // random addresses with half of them near a programmed base
    task automatic sweep_decode(input int count);
        logic [7:0] hi;
        repeat (count) begin
            hi = 8'($urandom);
            if ($urandom % 2) hi = m_base[$urandom % NUM_REGIONS] ^ (hi & 8'h07);
            cpu.addr = {hi, 15'($urandom)};
            cpu.fc   = 3'($urandom);
            step_clock();
        end
    endtask

    // active against the reference at mid-cycle
    always @(negedge clk) begin
        if (!rst) check_equal("active", active, decode_ref(cpu.addr, cpu.fc));
    end

    // enables take turns and cpu_cen keeps its CEN_NUM in CEN_DEN rate
    always @(negedge clk) begin
        if (rst) begin
            cen_last = 1'b0;
            cen_cnt  = 0;
            clk_cnt  = 0;
        end else begin
            if (cpu_cen || cpu_cenb) begin
                check_equal("cpu_cen", cpu_cen, !cen_last);
                check_equal("cpu_cenb", cpu_cenb, cen_last);
                cen_last = cpu_cen;
            end
            cen_cnt += cpu_cen;
            clk_cnt++;
            if (clk_cnt == CEN_DEN) begin
                check_equal("cpu_cen pulses per CEN_DEN clocks", cen_cnt, CEN_NUM);
                cen_cnt = 0;
                clk_cnt = 0;
            end
        end
    end

    initial begin
        void'($urandom(65475));
        rst       = 1'b1;
        cpu       = '0;
        cpu.as_n  = 1'b1;
        cpu.ds_n  = 2'b11;
        cpu.wr_n  = 2'b11;
        mcu       = '0;
        bus_cs    = 1'b0;
        bus_busy  = 1'b0;
        vint      = 1'b0;
        sndmap_rd = 1'b0;
        cpu_owns  = 1'b1;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            m_base[r]  = 8'h00;
            m_size[r]  = 2'd0;
            m_waits[r] = 2'd0;
        end
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        // reset state
        check_equal("dtack_n", dtack_n, 1'b1);
        check_equal("vpa_n", vpa_n, 1'b1);
        check_equal("ipl_n", ipl_n, 3'b111);
        check_equal("sndmap_obf", sndmap_obf, 1'b0);
        check_equal("active", active, 8'h01);
        cpu.addr = 23'h620000;      // byte address 0xc40000
        step_clock();
        check_equal("active", active, 8'h00);

        // random windows through CPU writes and a decode sweep
        for (int r = 0; r < NUM_REGIONS; r++) begin
            program_window(r, 8'($urandom) & 8'h0f, random_base());
        end
        sweep_decode(300);

        // disjoint 64 kB windows with the wait count checked inside each cycle
        for (int r = 0; r < NUM_REGIONS; r++) begin
            program_window(r, {4'h0, 2'($urandom), 2'd0}, 8'h10 * r + 8'h01);
        end
        for (int r = 0; r < NUM_REGIONS; r++) begin
            cpu_cycle({m_base[r], 16'($urandom)}, 3'd5, 1'b0, 16'h0000);
        end
        bus_cs   = 1'b1;
        bus_busy = 1'b1;
        fork
            cpu_cycle({m_base[3], 16'h0100}, 3'd5, 1'b0, 16'h0000);
            begin
                repeat (30) begin
                    step_clock();
                    check_equal("dtack_n while bus_busy", dtack_n, 1'b1);
                end
                bus_busy = 1'b0;    // shared bus ready so counting resumes
            end
        join
        bus_cs = 1'b0;

        // sound latch
        snd_byte = 8'($urandom);
        cpu_reg_write(REG_SND_LATCH, snd_byte);
        check_equal("sndmap_obf", sndmap_obf, 1'b1);
        check_equal("sndmap_dout", sndmap_dout, snd_byte);
        sndmap_rd = 1'b1;
        step_clock();
        sndmap_rd = 1'b0;
        check_equal("sndmap_obf", sndmap_obf, 1'b0);

        // vertical blank interrupt and its acknowledge
        vint = 1'b1;
        step_clock();
        check_equal("ipl_n", ipl_n, 3'b011);
        vint = 1'b0;
        step_clock();
        check_equal("ipl_n", ipl_n, 3'b011);
        cpu_cycle(24'hfffff8, FC_INT_ACK, 1'b0, 16'h0000);     // level 4 on a3..a1
        check_equal("ipl_n", ipl_n, 3'b111);

        // once the MCU takes the registers the CPU writes are ignored
        mcu_write(REG_REGION_BASE, 8'($urandom) & 8'h0f);
        for (int r = 0; r < NUM_REGIONS; r++) begin
            program_window(r, 8'($urandom) & 8'h0f, random_base());
        end
        sweep_decode(100);
        for (int r = 0; r < NUM_REGIONS; r++) begin
            mcu_write(5'(int'(REG_REGION_BASE) + 2*r), 8'($urandom) & 8'h0f);
            mcu_write(5'(int'(REG_REGION_BASE) + 2*r + 1), random_base());
        end
        sweep_decode(200);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
src/mapper_pkg.sv
src/mapper_regs.sv
src/region_decoder.sv
src/dtack_gen.sv
src/irq_ctrl.sv
src/cpu_mapper_top.sv
verif/mapper_properties.sv
verif/mapper_tb.sv
